/* NoiseUnit.sv */
// Noise generator; level advances on every tick whatever the shift and step, timer stays internal
`timescale 1ns/1ps
`include "noiseVoice_params.svh"

module NoiseUnit (
	input  logic                    clk,
	input  logic                    i_nrst,
	input  logic                    i_ctrl44Khz,
	input  logic [3:0]              i_noiseShift,
	input  logic [3:0]              i_noiseStep,
	output logic [`NV_NOISE_W-1:0] o_noiseOut
);

	logic [`NV_TIMER_W-1:0] noiseTimer;
	logic [`NV_NOISE_W-1:0] noiseLevel;

	// Inverted parity of the feedback taps
	logic feedBit;
	assign feedBit = ~(noiseLevel[15] ^ noiseLevel[12] ^ noiseLevel[11] ^ noiseLevel[10]);

	logic [`NV_NOISE_W-1:0] nextLevel;
	assign nextLevel = {noiseLevel[`NV_NOISE_W-2:0], feedBit};

	// Step arrives as 4..7 and is sign-extended to the timer width
	logic [`NV_TIMER_W-1:0] stepExt;
	logic [`NV_TIMER_W-1:0] timerStep;
	assign stepExt   = {{(`NV_TIMER_W-4){i_noiseStep[3]}}, i_noiseStep};
	assign timerStep = noiseTimer + stepExt;

	// One-hot offset where shift 0 selects the top bit
	logic [`NV_NOISE_W-1:0] shiftAdd;
	assign shiftAdd = 16'h8000 >> i_noiseShift;

	logic [`NV_TIMER_W-1:0] timerOfs1;
	logic [`NV_TIMER_W-1:0] timerOfs2;
	logic [`NV_TIMER_W-1:0] timerOfs;
	logic [`NV_TIMER_W-1:0] timerNext;

	assign timerOfs1 = timerStep + {1'b0, shiftAdd, 2'b00};
	assign timerOfs2 = timerStep + {shiftAdd, 3'b000};  // Second wrap adds twice the offset
	assign timerOfs  = timerOfs1[`NV_TIMER_W-1] ? timerOfs2 : timerOfs1;
	assign timerNext = timerStep[`NV_TIMER_W-1] ? timerOfs : timerStep;

	always_ff @(posedge clk) begin
		if (!i_nrst) begin
			noiseTimer <= '0;
			noiseLevel <= '0;
		end else if (i_ctrl44Khz) begin
			noiseTimer <= timerNext;
			noiseLevel <= nextLevel;
		end
	end

	// Word that the next tick loads
	assign o_noiseOut = nextLevel;

endmodule

/* noiseCtrlIf.sv */
// Decoded control and volumes; values change one cycle after the host write
`timescale 1ns/1ps
`include "noiseVoice_params.svh"

interface noiseCtrlIf;

	logic                        enable;     // Voice output enable
	logic [3:0]                  noiseShift; // Noise clock shift
	logic [3:0]                  noiseStep;  // Already widened to 4..7
	logic signed [`NV_VOL_W-1:0] volLeft;
	logic signed [`NV_VOL_W-1:0] volRight;

	// Register file side
	modport ctrlSrc (
		output enable,
		output noiseShift,
		output noiseStep,
		output volLeft,
		output volRight
	);

	// Generator and scaler side
	modport ctrlSink (
		input enable,
		input noiseShift,
		input noiseStep,
		input volLeft,
		input volRight
	);

endinterface

/* noiseRegFile.sv */
// Host register file; single-cycle write strobes, writes to address 3 are dropped, no readback
`timescale 1ns/1ps
`include "noiseVoice_params.svh"

module noiseRegFile (
	input  logic                 clk,
	input  logic                 i_nrst,
	input  logic                 i_wrEn,
	input  logic [`NV_ADDR_W-1:0] i_wrAddr,
	input  logic [15:0]          i_wrData,
	noiseCtrlIf.ctrlSrc          ctrl
);

	import spuNoisePkg::*;

	noiseCtrlWord_u               ctrlWord;
	logic signed [`NV_VOL_W-1:0] volLeft;
	logic signed [`NV_VOL_W-1:0] volRight;

	// Address decode
	logic wrCtrl;
	logic wrVolL;
	logic wrVolR;

	assign wrCtrl = i_wrEn && (i_wrAddr == `NV_ADDR_CTRL);
	assign wrVolL = i_wrEn && (i_wrAddr == `NV_ADDR_VOLL);
	assign wrVolR = i_wrEn && (i_wrAddr == `NV_ADDR_VOLR);

	always_ff @(posedge clk) begin
		if (!i_nrst) begin
			ctrlWord.raw <= '0;
			volLeft      <= '0;
			volRight     <= '0;
		end else begin
			if (wrCtrl) begin
				ctrlWord.raw <= i_wrData; // Raw view takes the whole word
			end
			if (wrVolL) begin
				volLeft <= $signed(i_wrData);
			end
			if (wrVolR) begin
				volRight <= $signed(i_wrData);
			end
		end
	end

	assign ctrl.enable     = ctrlWord.fields.enable;
	assign ctrl.noiseShift = ctrlWord.fields.shift;

	// Step field 0..3 is widened to 4..7 for the noise timer
	assign ctrl.noiseStep = {2'b01, ctrlWord.fields.step};

	assign ctrl.volLeft  = volLeft;
	assign ctrl.volRight = volRight;

	// Fields of a control write appear on the bus one cycle later
	assert property (@(posedge clk) disable iff (!i_nrst)
		wrCtrl |=> (ctrl.enable == $past(i_wrData[15])
			&& ctrl.noiseShift == $past(i_wrData[13:10])
			&& ctrl.noiseStep == 4'd4 + 4'($past(i_wrData[9:8]))))
		else $error("noiseRegFile: control fields wrong after a control write");

endmodule

/* noiseVoice.f */
+incdir+.
spuNoisePkg.sv
noiseCtrlIf.sv
noiseRegFile.sv
NoiseUnit.sv
noiseVolumeScaler.sv
noiseVoice.sv
tb_noiseVoice.sv

/* noiseVoice.sv */
// Noise voice top; host writes are strobes, the tick is a 44.1 kHz single-cycle pulse
`timescale 1ns/1ps
`include "noiseVoice_params.svh"

module noiseVoice (
	input  logic                        clk,
	input  logic                        i_nrst,
	input  logic                        i_wrEn,
	input  logic [`NV_ADDR_W-1:0]       i_wrAddr,
	input  logic [15:0]                 i_wrData,
	input  logic                        i_ctrl44Khz,
	output logic                        o_sampleValid,
	output logic signed [`NV_VOL_W-1:0] o_left,
	output logic signed [`NV_VOL_W-1:0] o_right
);

	noiseCtrlIf ctrlBus ();

	logic [`NV_NOISE_W-1:0] noiseWord;

	noiseRegFile u_regFile (
		.clk      (clk),
		.i_nrst   (i_nrst),
		.i_wrEn   (i_wrEn),
		.i_wrAddr (i_wrAddr),
		.i_wrData (i_wrData),
		.ctrl     (ctrlBus.ctrlSrc)
	);

	// Generator takes shift and step from the sink side of the bus
	NoiseUnit u_noise (
		.clk          (clk),
		.i_nrst       (i_nrst),
		.i_ctrl44Khz  (i_ctrl44Khz),
		.i_noiseShift (ctrlBus.noiseShift),
		.i_noiseStep  (ctrlBus.noiseStep),
		.o_noiseOut   (noiseWord)
	);

	noiseVolumeScaler u_scaler (
		.clk           (clk),
		.i_nrst        (i_nrst),
		.i_ctrl44Khz   (i_ctrl44Khz),
		.i_noise       (noiseWord),
		.ctrl          (ctrlBus.ctrlSink),
		.o_sampleValid (o_sampleValid),
		.o_left        (o_left),
		.o_right       (o_right)
	);

endmodule

/* noiseVoice_params.svh */
// Register map and widths for the noise voice; addresses are 2 bits and address 3 is unused
`ifndef NOISEVOICE_PARAMS_SVH
`define NOISEVOICE_PARAMS_SVH

// Host write address width
`define NV_ADDR_W 2

// Register addresses
`define NV_ADDR_CTRL 2'd0 // Enable, noise shift and noise step
`define NV_ADDR_VOLL 2'd1 // Left volume
`define NV_ADDR_VOLR 2'd2 // Right volume

// Volumes are read as signed values of this width
`define NV_VOL_W 16

// Noise word width, also the width of each output sample
`define NV_NOISE_W 16

// Product scaling, a volume of 0x7FFF is just under unity gain
`define NV_PROD_SHIFT 15

// Noise timer width, kept internal to the generator
`define NV_TIMER_W 19

`endif

/* noiseVolumeScaler.sv */
// Stereo output stage; captures on the tick edge, valid is a single-cycle pulse, no back-pressure
`timescale 1ns/1ps
`include "noiseVoice_params.svh"

module noiseVolumeScaler (
	input  logic                        clk,
	input  logic                        i_nrst,
	input  logic                        i_ctrl44Khz,
	input  logic [`NV_NOISE_W-1:0]     i_noise,
	noiseCtrlIf.ctrlSink                ctrl,
	output logic                        o_sampleValid,
	output logic signed [`NV_VOL_W-1:0] o_left,
	output logic signed [`NV_VOL_W-1:0] o_right
);

	localparam int ProdW = `NV_NOISE_W + `NV_VOL_W;

	logic signed [ProdW-1:0] prodLeft;
	logic signed [ProdW-1:0] prodRight;

	// Noise word read as signed
	assign prodLeft  = $signed(i_noise) * ctrl.volLeft;
	assign prodRight = $signed(i_noise) * ctrl.volRight;

	// Arithmetic shift then truncate, disabled voice is silent
	logic signed [`NV_VOL_W-1:0] sampleLeft;
	logic signed [`NV_VOL_W-1:0] sampleRight;

	assign sampleLeft  = ctrl.enable ? prodLeft[`NV_PROD_SHIFT +: `NV_VOL_W] : '0;
	assign sampleRight = ctrl.enable ? prodRight[`NV_PROD_SHIFT +: `NV_VOL_W] : '0;

	always_ff @(posedge clk) begin
		if (!i_nrst) begin
			o_sampleValid <= 1'b0;
			o_left        <= '0;
			o_right       <= '0;
		end else begin
			o_sampleValid <= i_ctrl44Khz; // One pulse per tick
			if (i_ctrl44Khz) begin
				o_left  <= sampleLeft;
				o_right <= sampleRight;
			end
		end
	end

	// A sample follows each tick by exactly one cycle, back-to-back ticks included
	assert property (@(posedge clk) disable iff (!i_nrst)
		$past(i_nrst) |-> (o_sampleValid == $past(i_ctrl44Khz)))
		else $error("noiseVolumeScaler: valid pulse out of step with tick");

endmodule

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f noiseVoice.f --top-module tb_noiseVoice -o tb_noiseVoice_sim

if ! ./obj_dir/tb_noiseVoice_sim > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -q "^tests failed$" sim.log; then
	exit 1
fi
grep -q "^all tests passed$" sim.log

/* spuNoisePkg.sv */
// Control word layout for the noise voice; reserved bits are stored but have no effect
package spuNoisePkg;

	// Field view of the control register
	typedef struct packed {
		logic       enable;    // Bit 15
		logic       rsvdHi;    // Bit 14
		logic [3:0] shift;     // Bits 13..10, noise clock shift
		logic [1:0] step;      // Bits 9..8, stored later as step+4
		logic [7:0] rsvdLo;    // Bits 7..0
	} noiseCtrlFields_t;

	// Same control word, raw and decoded
	typedef union packed {
		logic [15:0]      raw;
		noiseCtrlFields_t fields;
	} noiseCtrlWord_u;

endpackage

/* tb_noiseVoice.sv */
// Testbench for noiseVoice; needs assertions enabled, seed-42 LCG stimulus, cycle-limited run
`timescale 1ns/1ps
`include "noiseVoice_params.svh"

module tb_noiseVoice;

	localparam int ResetCycles    = 10;
	localparam int IdleCycles     = 40;
	localparam int MaxGap         = 3;          // Gap comes from two random bits
	localparam int TickCycles     = 1 + MaxGap; // Tick plus its longest gap
	localparam int FullScaleTicks = 200;
	localparam int VolumeTicks    = 100;
	localparam int DisabledTicks  = 50;
	localparam int Addr3Ticks     = 40;
	localparam int StepTicks      = 60;
	localparam int TailCycles     = 4;

	// Longest possible run with a quarter margin on top
	localparam int TestCycles = ResetCycles + IdleCycles + 3 + FullScaleTicks * TickCycles
		+ VolumeTicks * (TickCycles + 1) + 2 + 2 * DisabledTicks * TickCycles
		+ Addr3Ticks * (TickCycles + 1) + StepTicks * (TickCycles + 1) + TailCycles;
	localparam int TimeoutCycles = TestCycles + TestCycles / 4;

	localparam int TestIdle      = 0;
	localparam int TestFullScale = 1;
	localparam int TestVolume    = 2;
	localparam int TestDisable   = 3;
	localparam int TestAddr3     = 4;
	localparam int TestStep      = 5;
	localparam int TestEnd       = 6;

	logic                        clk;
	logic                        i_nrst;
	logic                        i_wrEn;
	logic [`NV_ADDR_W-1:0]       i_wrAddr;
	logic [15:0]                 i_wrData;
	logic                        i_ctrl44Khz;
	logic                        o_sampleValid;
	logic signed [`NV_VOL_W-1:0] o_left;
	logic signed [`NV_VOL_W-1:0] o_right;

	// Reference state updated as stimulus is driven
	logic [31:0]        lcgState;
	logic [15:0]        modelNoise;
	logic               shadowEn;
	logic signed [15:0] shadowVolL;
	logic signed [15:0] shadowVolR;
	int                 curTest;

	// Expectation for the tick being driven now
	logic signed [15:0] nextLeft;
	logic signed [15:0] nextRight;
	logic               nextEn;
	int                 nextId;

	// Expectation for the sample currently on the outputs
	logic signed [15:0] expLeftQ;
	logic signed [15:0] expRightQ;
	logic               expEnQ;
	int                 expIdQ;
	logic               tickQ;
	logic               tickSeenQ;

	int errorCount;
	int sampleCount;
	int ticksIssued;
	int cycleCount;

	noiseVoice UUT (
		.clk           (clk),
		.i_nrst        (i_nrst),
		.i_wrEn        (i_wrEn),
		.i_wrAddr      (i_wrAddr),
		.i_wrData      (i_wrData),
		.i_ctrl44Khz   (i_ctrl44Khz),
		.o_sampleValid (o_sampleValid),
		.o_left        (o_left),
		.o_right       (o_right)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic string testName(input int id);
		case (id)
			TestIdle:      return "reset_idle";
			TestFullScale: return "full_scale";
			TestVolume:    return "random_volume";
			TestDisable:   return "disable_enable";
			TestAddr3:     return "unused_address";
			TestStep:      return "shift_step";
			default:       return "end_of_run";
		endcase
	endfunction

	function automatic logic [15:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[30:15]; // Low LCG bits have short periods
	endfunction

	function automatic int randomGap();
		logic [15:0] rnd;
		rnd = nextRand();
		return int'(rnd[1:0]);
	endfunction

	// Shift left and feed in the inverted XOR of taps 15, 12, 11 and 10
	function automatic logic [15:0] advanceNoise(input logic [15:0] level);
		logic fb;
		fb = ~(level[15] ^ level[12] ^ level[11] ^ level[10]);
		return {level[14:0], fb};
	endfunction

	function automatic logic signed [15:0] scaleSample(input logic [15:0] noise,
		input logic signed [15:0] vol);
		logic signed [31:0] prod;
		logic signed [31:0] shifted;
		prod    = 32'($signed(noise)) * 32'(vol);
		shifted = prod >>> 15;
		return shifted[15:0];
	endfunction

	// One clock of stimulus; a tick sees the registers as they were before this edge
	task automatic driveCycle(input logic tick, input logic wr,
		input logic [`NV_ADDR_W-1:0] addr, input logic [15:0] data);
		i_ctrl44Khz = tick;
		i_wrEn      = wr;
		i_wrAddr    = addr;
		i_wrData    = data;
		if (tick) begin
			modelNoise = advanceNoise(modelNoise); // Keeps running while disabled
			nextEn     = shadowEn;
			nextLeft   = shadowEn ? scaleSample(modelNoise, shadowVolL) : 16'sd0;
			nextRight  = shadowEn ? scaleSample(modelNoise, shadowVolR) : 16'sd0;
			nextId     = curTest;
			ticksIssued++;
		end
		if (wr) begin
			case (addr)
				`NV_ADDR_CTRL: shadowEn   = data[15];
				`NV_ADDR_VOLL: shadowVolL = $signed(data);
				`NV_ADDR_VOLR: shadowVolR = $signed(data);
				default: ; // Address 3 holds nothing
			endcase
		end
		@(posedge clk);
		#1;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) driveCycle(1'b0, 1'b0, '0, '0);
	endtask

	task automatic writeReg(input logic [`NV_ADDR_W-1:0] addr, input logic [15:0] data);
		driveCycle(1'b0, 1'b1, addr, data);
	endtask

	task automatic sendTick(input int gap);
		driveCycle(1'b1, 1'b0, '0, '0);
		idleCycles(gap);
	endtask

	always @(posedge clk) begin
		if (!i_nrst) begin
			tickQ     <= 1'b0;
			tickSeenQ <= 1'b0;
			expLeftQ  <= '0;
			expRightQ <= '0;
			expEnQ    <= 1'b0;
			expIdQ    <= TestIdle;
		end else begin
			tickQ <= i_ctrl44Khz;
			if (i_ctrl44Khz) begin
				tickSeenQ <= 1'b1;
				expLeftQ  <= nextLeft;
				expRightQ <= nextRight;
				expEnQ    <= nextEn;
				expIdQ    <= nextId;
			end
		end
	end

	always @(posedge clk) begin
		if (i_nrst && o_sampleValid) begin
			sampleCount++;
		end
	end

	// Nothing comes out before the first tick
	idleQuiet: assert property (@(posedge clk) disable iff (!i_nrst)
		!tickSeenQ |-> (!o_sampleValid && o_left == 16'sd0 && o_right == 16'sd0))
		else begin
			errorCount++;
			$display(
				"mismatch %s: expected valid 0 left 0 right 0, actual valid %b left %h right %h",
				testName(TestIdle), $sampled(o_sampleValid), $sampled(o_left), $sampled(o_right));
		end

	validPulse: assert property (@(posedge clk) disable iff (!i_nrst)
		o_sampleValid == tickQ)
		else begin
			errorCount++;
			$display("mismatch %s valid: expected %b, actual %b",
				testName(curTest), $sampled(tickQ), $sampled(o_sampleValid));
		end

	leftValue: assert property (@(posedge clk) disable iff (!i_nrst)
		o_sampleValid |-> (o_left == expLeftQ))
		else begin
			errorCount++;
			$display("mismatch %s left: expected %h, actual %h",
				testName(expIdQ), $sampled(expLeftQ), $sampled(o_left));
		end

	rightValue: assert property (@(posedge clk) disable iff (!i_nrst)
		o_sampleValid |-> (o_right == expRightQ))
		else begin
			errorCount++;
			$display("mismatch %s right: expected %h, actual %h",
				testName(expIdQ), $sampled(expRightQ), $sampled(o_right));
		end

	disabledSilent: assert property (@(posedge clk) disable iff (!i_nrst)
		(o_sampleValid && !expEnQ) |-> (o_left == 16'sd0 && o_right == 16'sd0))
		else begin
			errorCount++;
			$display("mismatch %s disabled: expected 0000 0000, actual %h %h",
				testName(expIdQ), $sampled(o_left), $sampled(o_right));
		end

	// Outputs move only together with a valid pulse
	holdBetween: assert property (@(posedge clk) disable iff (!i_nrst)
		!o_sampleValid |-> ($stable(o_left) && $stable(o_right)))
		else begin
			errorCount++;
			$display("output changed without a valid pulse during %s", testName(curTest));
		end

	initial begin
		logic [15:0] data;
		i_nrst      = 1'b0;
		i_wrEn      = 1'b0;
		i_wrAddr    = '0;
		i_wrData    = '0;
		i_ctrl44Khz = 1'b0;
		lcgState    = 32'd42;
		modelNoise  = '0;
		shadowEn    = 1'b0;
		shadowVolL  = '0;
		shadowVolR  = '0;
		nextLeft    = '0;
		nextRight   = '0;
		nextEn      = 1'b0;
		nextId      = TestIdle;
		curTest     = TestIdle;
		errorCount  = 0;
		sampleCount = 0;
		ticksIssued = 0;

		repeat (ResetCycles) @(posedge clk);
		#1;
		i_nrst = 1'b1;
		idleCycles(IdleCycles);

		curTest = TestFullScale;
		writeReg(`NV_ADDR_CTRL, 16'h8000);
		writeReg(`NV_ADDR_VOLL, 16'h7FFF);
		writeReg(`NV_ADDR_VOLR, 16'h7FFF);
		repeat (FullScaleTicks) sendTick(randomGap()); // Gap 0 gives back-to-back ticks

		curTest = TestVolume;
		repeat (VolumeTicks) begin
			writeReg(`NV_ADDR_VOLL, nextRand());
			data = nextRand();
			driveCycle(1'b1, 1'b1, `NV_ADDR_VOLR, data); // Tick on this edge keeps the old right volume
			idleCycles(randomGap());
		end

		curTest = TestDisable;
		writeReg(`NV_ADDR_CTRL, 16'h0000);
		repeat (DisabledTicks) sendTick(randomGap());
		writeReg(`NV_ADDR_CTRL, 16'h8000);
		repeat (DisabledTicks) sendTick(randomGap());

		curTest = TestAddr3;
		repeat (Addr3Ticks) begin
			writeReg(2'd3, nextRand());
			sendTick(randomGap());
		end

		curTest = TestStep;
		repeat (StepTicks) begin
			data = nextRand();
			writeReg(`NV_ADDR_CTRL, 16'h8000 | (data & 16'h3F00));
			sendTick(randomGap());
		end

		curTest = TestEnd;
		idleCycles(TailCycles);
		if (sampleCount != ticksIssued) begin
			errorCount++;
			$display("mismatch %s sample count: expected %0d, actual %0d",
				testName(TestEnd), ticksIssued, sampleCount);
		end

		$display("closing: %0d errors, %0d samples checked", errorCount, sampleCount);
		if (errorCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < TimeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		errorCount++;
		$display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
		$display("closing: %0d errors, %0d samples checked", errorCount, sampleCount);
		$display("tests failed");
		$finish;
	end

endmodule
